/* common/serial_arith_params.svh */
`ifndef SERIAL_ARITH_PARAMS_SVH
`define SERIAL_ARITH_PARAMS_SVH

// width of one word that passes through the word adder per clock
`define WORD_WIDTH 16

// number of words in each wide operand, which is also the run length in cycles
`define NUM_WORDS 8

// full operand and result width, kept derived so the two above stay the only knobs
`define OPERAND_WIDTH ((`WORD_WIDTH) * (`NUM_WORDS))

`endif

/* common/serial_arith_pkg.sv */
`include "serial_arith_params.svh"

package serial_arith_pkg;

    // opcode encoding follows the word adder, where 0 adds and 1 subtracts
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } arith_op_e;

    // the controller is either waiting for start or stepping through words
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } ctrl_state_e;

    // a single word still needs one counter bit so the type never collapses
    localparam int COUNT_WIDTH = (`NUM_WORDS > 1) ? $clog2(`NUM_WORDS) : 1;

    // index of the word currently in the adder, 0 up to NUM_WORDS-1
    typedef logic [COUNT_WIDTH-1:0] word_count_t;

endpackage

/* serial_arith/adder_subtractor_binary.sv */
`timescale 1ns/1ps
`include "serial_arith_params.svh"

module adder_subtractor_binary (
    input  serial_arith_pkg::arith_op_e add_sub,
    input  logic                        carry_in,
    input  logic [`WORD_WIDTH-1:0]      a_in,
    input  logic [`WORD_WIDTH-1:0]      b_in,
    output logic [`WORD_WIDTH-1:0]      sum_out,
    output logic                        carry_out
);

    import serial_arith_pkg::*;

    // one extra bit on top catches the carry, or the borrow when subtracting
    logic [`WORD_WIDTH:0] a_ext;
    logic [`WORD_WIDTH:0] b_ext;
    logic [`WORD_WIDTH:0] carry_ext;
    logic [`WORD_WIDTH:0] full_sum;

    // everything is zero extended, so no signed arithmetic rules come into play
    assign a_ext     = {1'b0, a_in};
    assign b_ext     = {1'b0, b_in};
    assign carry_ext = {{`WORD_WIDTH{1'b0}}, carry_in};

    // a plain + or - lets synthesis map this onto the dedicated carry chain
    always_comb begin
        if (add_sub == OP_ADD) begin
            full_sum = a_ext + b_ext + carry_ext;
        end else begin
            // the top bit wraps to 1 exactly when a borrow leaves the word
            full_sum = a_ext - b_ext - carry_ext;
        end
    end

    assign sum_out   = full_sum[`WORD_WIDTH-1:0];
    assign carry_out = full_sum[`WORD_WIDTH];

endmodule

/* serial_arith/operand_shifter.sv */
`timescale 1ns/1ps
`include "serial_arith_params.svh"

module operand_shifter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic                       shift,
    input  logic [`OPERAND_WIDTH-1:0]  a,
    input  logic [`OPERAND_WIDTH-1:0]  b,
    output logic [`WORD_WIDTH-1:0]     a_word,
    output logic [`WORD_WIDTH-1:0]     b_word
);

    // both operands live here for the whole run and drain one word per step
    logic [`OPERAND_WIDTH-1:0] a_q;
    logic [`OPERAND_WIDTH-1:0] b_q;

    // load wins over shift, although the controller never raises both at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (load) begin
            a_q <= a;
            b_q <= b;
        end else if (shift) begin
            // zeros fill in at the top as the used words fall off the bottom
            a_q <= {{`WORD_WIDTH{1'b0}}, a_q[`OPERAND_WIDTH-1:`WORD_WIDTH]};
            b_q <= {{`WORD_WIDTH{1'b0}}, b_q[`OPERAND_WIDTH-1:`WORD_WIDTH]};
        end
    end

    // the least significant word goes first, so the carry ripples upward
    // through the words in the right order
    assign a_word = a_q[`WORD_WIDTH-1:0];
    assign b_word = b_q[`WORD_WIDTH-1:0];

endmodule

/* serial_arith/result_shifter.sv */
`timescale 1ns/1ps
`include "serial_arith_params.svh"

module result_shifter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic                       shift,
    input  logic                       carry_in,
    input  logic [`WORD_WIDTH-1:0]     sum_word,
    input  logic                       word_carry,
    output logic                       carry,
    output logic [`OPERAND_WIDTH-1:0]  result,
    output logic                       carry_out
);

    logic                      carry_q;
    logic [`OPERAND_WIDTH-1:0] result_q;

    // the carry register links one word to the next
    // it starts from the external carry in and then follows each word's carry out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (load) begin
            carry_q <= carry_in;
        end else if (shift) begin
            carry_q <= word_carry;
        end
    end

    // new words enter at the top and move down, so after NUM_WORDS steps
    // word 0 has reached the bottom and every word sits in its place
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (shift) begin
            result_q <= {sum_word, result_q[`OPERAND_WIDTH-1:`WORD_WIDTH]};
        end
    end

    // the adder sees the chained carry during the run
    assign carry = carry_q;

    // once the run ends the same register holds the top word's carry or borrow
    assign carry_out = carry_q;

    // result is only complete in the done cycle, and holds until the next start
    assign result = result_q;

endmodule

/* serial_arith/arith_control.sv */
`timescale 1ns/1ps
`include "serial_arith_params.svh"

module arith_control (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  serial_arith_pkg::arith_op_e op,
    output logic                        load,
    output logic                        shift,
    output serial_arith_pkg::arith_op_e op_q,
    output logic                        busy,
    output logic                        done
);

    import serial_arith_pkg::*;

    // index of the final word, where the run wraps up
    localparam word_count_t LAST_COUNT = word_count_t'(`NUM_WORDS - 1);

    ctrl_state_e state;
    ctrl_state_e state_next;
    word_count_t count;
    logic        last_word;

    // start only counts while idle, so a pulse during a run is simply dropped
    assign load = (state == ST_IDLE) && start;

    // the datapath steps on every run cycle, and busy covers the same span
    assign shift = (state == ST_RUN);
    assign busy  = (state == ST_RUN);

    assign last_word = (count == LAST_COUNT);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                // the final word gets registered at the edge that leaves this state
                if (last_word) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // the counter restarts on every accepted start, so it is always 0 for word 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (shift) begin
            count <= count + 1'b1;
        end
    end

    // the opcode is held for the whole run, so the op input may change after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= OP_ADD;
        end else if (load) begin
            op_q <= op;
        end
    end

    // done rises with the last word and busy falls at that same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= shift && last_word;
        end
    end

endmodule

/* verilog/serial_arith_top.sv */
`timescale 1ns/1ps
`include "serial_arith_params.svh"

module serial_arith_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  serial_arith_pkg::arith_op_e op,
    input  logic                        carry_in,
    input  logic [`OPERAND_WIDTH-1:0]   a,
    input  logic [`OPERAND_WIDTH-1:0]   b,
    output logic [`OPERAND_WIDTH-1:0]   result,
    output logic                        carry_out,
    output logic                        busy,
    output logic                        done
);

    import serial_arith_pkg::*;

    // strobes from the controller to the datapath
    logic      load;
    logic      shift;
    arith_op_e op_q;

    // word-wide path through the single adder
    logic [`WORD_WIDTH-1:0] a_word;
    logic [`WORD_WIDTH-1:0] b_word;
    logic [`WORD_WIDTH-1:0] sum_word;
    logic                   word_carry;
    logic                   carry;

    arith_control u_control (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .op    (op),
        .load  (load),
        .shift (shift),
        .op_q  (op_q),
        .busy  (busy),
        .done  (done)
    );

    operand_shifter u_operands (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .shift  (shift),
        .a      (a),
        .b      (b),
        .a_word (a_word),
        .b_word (b_word)
    );

    // Purely combinational, so each word settles within the cycle it is presented.
    adder_subtractor_binary u_adder (
        .add_sub   (op_q),
        .carry_in  (carry),
        .a_in      (a_word),
        .b_in      (b_word),
        .sum_out   (sum_word),
        .carry_out (word_carry)
    );

    // the external carry in seeds the chain here and not at the adder
    result_shifter u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .shift      (shift),
        .carry_in   (carry_in),
        .sum_word   (sum_word),
        .word_carry (word_carry),
        .carry      (carry),
        .result     (result),
        .carry_out  (carry_out)
    );

endmodule

/* testbench/serial_arith_assertions.sv */
`timescale 1ns/1ps

module serial_arith_assertions (
    input logic clk,
    input logic rst_n,
    input logic load,
    input logic busy,
    input logic done
);

    // done is a strobe that never lasts past one cycle
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // the run has ended by the time done shows
    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(done && busy))
        else $error("done and busy were high together");

    // an operation is only accepted while idle, and it opens a new run on the next edge
    load_when_idle: assert property (@(posedge clk) disable iff (!rst_n) load |=> $rose(busy))
        else $error("load did not come from idle or did not start a run");

    // the end of busy and the start of done share one edge, in both directions
    busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $rose(done))
        else $error("busy fell without done rising");

    done_rises_with_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $fell(busy))
        else $error("done rose without busy falling");

endmodule

bind serial_arith_top serial_arith_assertions u_assertions (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .busy  (busy),
    .done  (done)
);

/* testbench/serial_arith_tb.sv */
`timescale 1ns/1ps
`include "serial_arith_params.svh"

module serial_arith_tb;

    import serial_arith_pkg::*;

    localparam int OW = `OPERAND_WIDTH;
    localparam int NW = `NUM_WORDS;
    // the directed cases are counted inside the total number of operations
    localparam int NUM_OPS = 200;
    localparam int NUM_DIRECTED = 4;
    // every operation takes NUM_WORDS cycles plus a few idle ones, with room for reset
    localparam int TIMEOUT_CYCLES = NUM_OPS * (NW + 4) + 50;

    typedef logic [OW-1:0] operand_t;

    logic      clk;
    logic      rst_n;
    logic      start;
    arith_op_e op;
    logic      carry_in;
    operand_t  a;
    operand_t  b;
    operand_t  result;
    logic      carry_out;
    logic      busy;
    logic      done;
    integer    seed;
    int        cycle_count;

    serial_arith_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .op        (op),
        .carry_in  (carry_in),
        .a         (a),
        .b         (b),
        .result    (result),
        .carry_out (carry_out),
        .busy      (busy),
        .done      (done)
    );

    always #2 clk = ~clk;

    // a lost done would otherwise leave the run waiting forever
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the operations did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // reference for the whole width at once, with no word splitting at all
    function automatic logic [OW:0] wide_model(input arith_op_e f_op, input logic cin,
                                               input operand_t x, input operand_t y);
        logic [OW:0] cin_ext;
        logic        borrow;
        cin_ext = {{OW{1'b0}}, cin};
        if (f_op == OP_ADD) begin
            return {1'b0, x} + {1'b0, y} + cin_ext;
        end
        // a borrow leaves the top when y plus the incoming borrow exceeds x
        borrow = ({1'b0, x} < ({1'b0, y} + cin_ext));
        return {borrow, x - y - operand_t'(cin)};
    endfunction

    // operands are stitched together from 32 bit random words
    function automatic operand_t random_operand();
        operand_t value;
        value = '0;
        for (int i = 0; i < (OW + 31) / 32; i++) begin
            value = (value << 32) | operand_t'($unsigned($random(seed)));
        end
        return value;
    endfunction

    task automatic check_equal(input string name, input operand_t expected,
                               input operand_t actual);
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // issues one operation, follows it to done and checks timing and results
    // with intrude set a second start with other operands arrives mid run
    task automatic run_op(input arith_op_e t_op, input logic t_cin, input operand_t t_a,
                          input operand_t t_b, input operand_t exp_result,
                          input logic exp_carry, input bit intrude);
        int edges;
        edges = 0;
        @(negedge clk);
        start    = 1'b1;
        op       = t_op;
        carry_in = t_cin;
        a        = t_a;
        b        = t_b;
        do begin
            @(negedge clk);
            edges++;
            if (!done) begin
                check_equal("busy", operand_t'(1), operand_t'(busy));
            end
            if (intrude && edges == 2) begin
                start    = 1'b1;
                op       = (t_op == OP_ADD) ? OP_SUB : OP_ADD;
                carry_in = ~t_cin;
                a        = random_operand();
                b        = random_operand();
            end else begin
                start = 1'b0;
            end
        end while (!done);
        // the first falling edge already lies after the accepting rising edge
        check_equal("done latency", operand_t'(NW), operand_t'(edges - 1));
        check_equal("busy", operand_t'(0), operand_t'(busy));
        check_equal("result", exp_result, result);
        check_equal("carry_out", operand_t'(exp_carry), operand_t'(carry_out));
        if (intrude) begin
            // the dropped start must neither restart the run nor touch the result
            repeat (NW + 2) begin
                @(negedge clk);
                check_equal("done", operand_t'(0), operand_t'(done));
                check_equal("busy", operand_t'(0), operand_t'(busy));
                check_equal("result", exp_result, result);
                check_equal("carry_out", operand_t'(exp_carry), operand_t'(carry_out));
            end
        end
    endtask

    initial begin
        logic [OW:0] expected;
        logic [31:0] rnd;
        arith_op_e   r_op;
        operand_t    r_a;
        operand_t    r_b;
        seed        = 32'h4d1d_d0ca;
        cycle_count = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        op          = OP_ADD;
        carry_in    = 1'b0;
        a           = '0;
        b           = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_equal("busy", operand_t'(0), operand_t'(busy));
        check_equal("done", operand_t'(0), operand_t'(done));
        check_equal("result", '0, result);
        check_equal("carry_out", operand_t'(0), operand_t'(carry_out));

        // carry and borrow have to ripple through every word
        run_op(OP_ADD, 1'b1, '1, '0, '0, 1'b1, 1'b0);
        run_op(OP_SUB, 1'b1, '0, '0, '1, 1'b1, 1'b0);
        run_op(OP_ADD, 1'b1, '1, '1, '1, 1'b1, 1'b0);

        r_a      = random_operand();
        r_b      = random_operand();
        expected = wide_model(OP_SUB, 1'b0, r_a, r_b);
        run_op(OP_SUB, 1'b0, r_a, r_b, expected[OW-1:0], expected[OW], 1'b1);

        for (int n = 0; n < NUM_OPS - NUM_DIRECTED; n++) begin
            rnd      = $random(seed);
            r_op     = rnd[0] ? OP_SUB : OP_ADD;
            r_a      = random_operand();
            r_b      = random_operand();
            expected = wide_model(r_op, rnd[1], r_a, r_b);
            run_op(r_op, rnd[1], r_a, r_b, expected[OW-1:0], expected[OW], 1'b0);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/serial_arith_pkg.sv
serial_arith/adder_subtractor_binary.sv
serial_arith/operand_shifter.sv
serial_arith/result_shifter.sv
serial_arith/arith_control.sv
verilog/serial_arith_top.sv
testbench/serial_arith_assertions.sv
testbench/serial_arith_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= serial_arith_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert

FAIL_MSG = Simulation FAILED
PASS_MSG = Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
